// ==== sources.f ====
src/exec_pkg.sv
src/alu_stage.sv
src/div_pipeline.sv
src/div_tag_fifo.sv
src/result_merge.sv
src/execute_port.sv
testbench/tb_execute_port.sv

// ==== src/alu_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_stage (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input exec_pkg::issue_t issue,
	input logic hold,
	output exec_pkg::result_t alu_result
);
	import exec_pkg::*;

	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] op_b;
	logic [4:0] shamt;
	logic [DATA_W:0] sum;
	logic [DATA_W:0] diff;
	logic add_of;
	logic sub_of;
	logic [2*DATA_W-1:0] prod;
	logic [2*DATA_W-1:0] rol_tmp;
	logic [2*DATA_W-1:0] ror_tmp;
	logic [DATA_W-1:0] logic_data;
	logic [DATA_W-1:0] shift_data;
	logic [DATA_W-1:0] sel_data;
	logic sel_cf;
	logic sel_of;
	flags_t sel_flags;
	result_t next_result;

	assign op_a = issue.src0;
	assign op_b = issue.src1;
	assign shamt = issue.src1[4:0];

	// Adder, with one extra bit for carry and borrow
	assign sum = {1'b0, op_a} + {1'b0, op_b};
	assign diff = {1'b0, op_a} - {1'b0, op_b};
	assign add_of = (op_a[DATA_W-1] == op_b[DATA_W-1]) && (sum[DATA_W-1] != op_a[DATA_W-1]);
	assign sub_of = (op_a[DATA_W-1] != op_b[DATA_W-1]) && (diff[DATA_W-1] != op_a[DATA_W-1]);

	// Full unsigned product, low or high word picked below
	assign prod = op_a * op_b;

	// Rotates through a doubled word
	assign rol_tmp = {op_a, op_a} << shamt;
	assign ror_tmp = {op_a, op_a} >> shamt;

	always_comb begin
		case (issue.cmd)
			CMD_LOGIC_BUF1: logic_data = op_b;
			CMD_LOGIC_AND:  logic_data = op_a & op_b;
			CMD_LOGIC_OR:   logic_data = op_a | op_b;
			CMD_LOGIC_XOR:  logic_data = op_a ^ op_b;
			CMD_LOGIC_NOT:  logic_data = ~op_a;
			CMD_LOGIC_NAND: logic_data = ~(op_a & op_b);
			CMD_LOGIC_NOR:  logic_data = ~(op_a | op_b);
			CMD_LOGIC_XNOR: logic_data = ~(op_a ^ op_b);
			default:        logic_data = '0;
		endcase
	end

	always_comb begin
		case (issue.cmd)
			CMD_SHIFT_SLL: shift_data = op_a << shamt;
			CMD_SHIFT_SRL: shift_data = op_a >> shamt;
			CMD_SHIFT_SRA: shift_data = $signed(op_a) >>> shamt;
			CMD_SHIFT_ROL: shift_data = rol_tmp[2*DATA_W-1:DATA_W];
			CMD_SHIFT_ROR: shift_data = ror_tmp[DATA_W-1:0];
			default:       shift_data = '0;
		endcase
	end

	// Unit select
	always_comb begin
		sel_data = '0;
		sel_cf = 1'b0;
		sel_of = 1'b0;
		case (issue.unit)
			UNIT_LOGIC: begin
				sel_data = logic_data;
			end
			UNIT_SHIFT: begin
				sel_data = shift_data;
			end
			UNIT_ADDER: begin
				if (issue.cmd == CMD_SUB) begin
					sel_data = diff[DATA_W-1:0];
					sel_cf = diff[DATA_W];
					sel_of = sub_of;
				end else begin
					sel_data = sum[DATA_W-1:0];
					sel_cf = sum[DATA_W];
					sel_of = add_of;
				end
			end
			UNIT_MUL: begin
				if (issue.cmd == CMD_UMULH) begin
					sel_data = prod[2*DATA_W-1:DATA_W];
				end else begin
					sel_data = prod[DATA_W-1:0];
					sel_cf = prod[DATA_W];
					sel_of = prod[DATA_W-1] ^ prod[DATA_W];
				end
			end
			default: begin
				sel_data = '0;
			end
		endcase
	end

	// sf, pf and zf come from the result word for every unit
	assign sel_flags = '{
		sf: sel_data[DATA_W-1],
		of: sel_of,
		cf: sel_cf,
		pf: sel_data[0],
		zf: (sel_data == '0)
	};

	always_comb begin
		next_result.valid = issue.valid && (issue.unit != UNIT_DIV);
		next_result.tag = issue.tag;
		next_result.dest = issue.dest;
		next_result.writeback = issue.writeback;
		next_result.data = sel_data;
		next_result.flags = sel_flags;
		next_result.flags_wb = issue.flags_wb;
		next_result.flags_dest = issue.flags_dest;
	end

	// Held while the divider owns the completion port
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			alu_result.valid <= 1'b0;
		end else if (flush) begin
			alu_result.valid <= 1'b0;
		end else if (!hold) begin
			alu_result <= next_result;
		end
	end

endmodule

`default_nettype wire

// ==== src/div_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_pipeline #(
	parameter int DIV_BITS_PER_STAGE = 4
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic start,
	input logic signed_op,
	input logic [exec_pkg::DATA_W-1:0] dividend,
	input logic [exec_pkg::DATA_W-1:0] divisor,
	output logic div_valid,
	output logic [exec_pkg::DATA_W-1:0] quotient,
	output logic [exec_pkg::DATA_W-1:0] remainder
);
	import exec_pkg::*;

	localparam int STAGES = DATA_W / DIV_BITS_PER_STAGE;

	// Partial state of one divide between stages
	typedef struct packed {
		logic q_neg;
		logic r_neg;
		logic zero_div;
		logic [DATA_W-1:0] rem;
		logic [DATA_W-1:0] quo;
		logic [DATA_W-1:0] dvs;
	} stage_t;

	logic a_neg;
	logic b_neg;
	stage_t entry;
	stage_t stage_q [STAGES];
	stage_t last;
	logic [STAGES-1:0] stage_valid;

	// Restoring steps; quo shifts the dividend out and the quotient in
	function automatic logic [2*DATA_W-1:0] radix2_steps(
		input logic [DATA_W-1:0] rem_in,
		input logic [DATA_W-1:0] quo_in,
		input logic [DATA_W-1:0] dvs
	);
		logic [DATA_W-1:0] rem;
		logic [DATA_W-1:0] quo;
		logic [DATA_W:0] trial;
		rem = rem_in;
		quo = quo_in;
		for (int n = 0; n < DIV_BITS_PER_STAGE; n++) begin
			trial = {rem, quo[DATA_W-1]} - {1'b0, dvs};
			if (!trial[DATA_W]) begin
				rem = trial[DATA_W-1:0];
				quo = {quo[DATA_W-2:0], 1'b1};
			end else begin
				rem = {rem[DATA_W-2:0], quo[DATA_W-1]};
				quo = {quo[DATA_W-2:0], 1'b0};
			end
		end
		return {rem, quo};
	endfunction

	// Magnitudes and result signs at entry
	assign a_neg = signed_op && dividend[DATA_W-1];
	assign b_neg = signed_op && divisor[DATA_W-1];

	always_comb begin
		entry.q_neg = a_neg ^ b_neg;
		entry.r_neg = a_neg;
		entry.zero_div = (divisor == '0);
		entry.rem = '0;
		entry.quo = a_neg ? -dividend : dividend;
		entry.dvs = b_neg ? -divisor : divisor;
	end

	for (genvar i = 0; i < STAGES; i++) begin : g_stage
		stage_t prev_stage;
		stage_t next_stage;

		if (i == 0) begin : g_first
			assign prev_stage = entry;
		end else begin : g_next
			assign prev_stage = stage_q[i-1];
		end

		always_comb begin
			next_stage = prev_stage;
			{next_stage.rem, next_stage.quo} =
				radix2_steps(prev_stage.rem, prev_stage.quo, prev_stage.dvs);
		end

		always_ff @(posedge iCLOCK) begin
			stage_q[i] <= next_stage;
		end
	end

	// One valid per stage, all dropped on flush
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			stage_valid <= '0;
		end else if (flush) begin
			stage_valid <= '0;
		end else begin
			stage_valid <= (stage_valid << 1) | STAGES'(start);
		end
	end

	assign last = stage_q[STAGES-1];
	assign div_valid = stage_valid[STAGES-1];

	// Divide by zero: all ones quotient, remainder is the dividend again
	assign quotient = last.zero_div ? '1 : (last.q_neg ? -last.quo : last.quo);
	assign remainder = last.r_neg ? -last.rem : last.rem;

endmodule

`default_nettype wire

// ==== src/div_tag_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_tag_fifo #(
	parameter int DEPTH = 16,
	parameter int DEPTH_W = 4
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic push,
	input exec_pkg::div_meta_t push_meta,
	input logic pop,
	output exec_pkg::div_meta_t head_meta
);
	import exec_pkg::*;

	div_meta_t mem [DEPTH];
	logic [DEPTH_W-1:0] wr_ptr;
	logic [DEPTH_W-1:0] rd_ptr;

	function automatic logic [DEPTH_W-1:0] ptr_inc(input logic [DEPTH_W-1:0] ptr);
		if (ptr == DEPTH_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// Storage
	always_ff @(posedge iCLOCK) begin
		if (push) begin
			mem[wr_ptr] <= push_meta;
		end
	end

	// Pointers; pops only come with a divider completion, so never empty
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
		end
	end

	// Oldest divide in flight
	assign head_meta = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== src/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

	localparam int DATA_W = 32;
	localparam int TAG_W = 6;
	localparam int DEST_W = 6;
	localparam int FLAGS_DEST_W = 4;

	typedef enum logic [2:0] {
		UNIT_LOGIC = 3'd0,
		UNIT_SHIFT = 3'd1,
		UNIT_ADDER = 3'd2,
		UNIT_MUL   = 3'd3,
		UNIT_DIV   = 3'd4
	} unit_t;

	// Meaning depends on the unit
	typedef logic [3:0] cmd_t;

	// Logic unit, BUF1 passes source 1 through
	localparam cmd_t CMD_LOGIC_BUF1 = 4'h0;
	localparam cmd_t CMD_LOGIC_AND  = 4'h1;
	localparam cmd_t CMD_LOGIC_OR   = 4'h2;
	localparam cmd_t CMD_LOGIC_XOR  = 4'h3;
	localparam cmd_t CMD_LOGIC_NOT  = 4'h4;
	localparam cmd_t CMD_LOGIC_NAND = 4'h5;
	localparam cmd_t CMD_LOGIC_NOR  = 4'h6;
	localparam cmd_t CMD_LOGIC_XNOR = 4'h7;

	// Shift unit, amount in source 1 bits 4..0
	localparam cmd_t CMD_SHIFT_SLL = 4'h0;
	localparam cmd_t CMD_SHIFT_SRL = 4'h1;
	localparam cmd_t CMD_SHIFT_SRA = 4'h2;
	localparam cmd_t CMD_SHIFT_ROL = 4'h3;
	localparam cmd_t CMD_SHIFT_ROR = 4'h4;

	localparam cmd_t CMD_ADD = 4'h0;
	localparam cmd_t CMD_SUB = 4'h1;

	localparam cmd_t CMD_MUL   = 4'h0;
	localparam cmd_t CMD_UMULH = 4'h1;

	localparam cmd_t CMD_UDIV = 4'h0;
	localparam cmd_t CMD_UMOD = 4'h1;
	localparam cmd_t CMD_SDIV = 4'h2;
	localparam cmd_t CMD_SMOD = 4'h3;

	typedef struct packed {
		logic sf;
		logic of;
		logic cf;
		logic pf;
		logic zf;
	} flags_t;

	typedef struct packed {
		logic valid;
		unit_t unit;
		cmd_t cmd;
		logic [DATA_W-1:0] src0;
		logic [DATA_W-1:0] src1;
		logic [TAG_W-1:0] tag;
		logic [DEST_W-1:0] dest;
		logic writeback;
		logic flags_wb;
		logic [FLAGS_DEST_W-1:0] flags_dest;
	} issue_t;

	typedef struct packed {
		logic valid;
		logic [TAG_W-1:0] tag;
		logic [DEST_W-1:0] dest;
		logic writeback;
		logic [DATA_W-1:0] data;
		flags_t flags;
		logic flags_wb;
		logic [FLAGS_DEST_W-1:0] flags_dest;
	} result_t;

	// One entry per divide in flight
	typedef struct packed {
		logic mod_sel;
		logic [TAG_W-1:0] tag;
		logic [DEST_W-1:0] dest;
	} div_meta_t;

endpackage

`default_nettype wire

// ==== src/execute_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_port #(
	parameter int DIV_BITS_PER_STAGE = 4,
	parameter int FIFO_DEPTH = 16,
	parameter int FIFO_DEPTH_W = 4
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input exec_pkg::issue_t issue,
	output exec_pkg::result_t result,
	output logic lock
);
	import exec_pkg::*;

	logic issue_is_div;
	logic div_signed;
	div_meta_t div_push_meta;
	div_meta_t div_meta;
	logic div_valid;
	logic [DATA_W-1:0] quotient;
	logic [DATA_W-1:0] remainder;
	result_t alu_result;
	logic alu_hold;

	// Divide decode
	assign issue_is_div = issue.valid && (issue.unit == UNIT_DIV);
	assign div_signed = (issue.cmd == CMD_SDIV) || (issue.cmd == CMD_SMOD);
	assign div_push_meta = '{
		mod_sel: (issue.cmd == CMD_UMOD) || (issue.cmd == CMD_SMOD),
		tag: issue.tag,
		dest: issue.dest
	};

	alu_stage u_alu (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.issue(issue),
		.hold(alu_hold),
		.alu_result(alu_result)
	);

	div_pipeline #(
		.DIV_BITS_PER_STAGE(DIV_BITS_PER_STAGE)
	) u_div (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.start(issue_is_div),
		.signed_op(div_signed),
		.dividend(issue.src0),
		.divisor(issue.src1),
		.div_valid(div_valid),
		.quotient(quotient),
		.remainder(remainder)
	);

	// Tag and destination ride alongside the divider
	div_tag_fifo #(
		.DEPTH(FIFO_DEPTH),
		.DEPTH_W(FIFO_DEPTH_W)
	) u_div_fifo (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.push(issue_is_div),
		.push_meta(div_push_meta),
		.pop(div_valid),
		.head_meta(div_meta)
	);

	result_merge u_merge (
		.alu_result(alu_result),
		.div_valid(div_valid),
		.quotient(quotient),
		.remainder(remainder),
		.div_meta(div_meta),
		.issue_is_div(issue_is_div),
		.result(result),
		.lock(lock),
		.alu_hold(alu_hold)
	);

endmodule

`default_nettype wire

// ==== src/result_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_merge (
	input exec_pkg::result_t alu_result,
	input logic div_valid,
	input logic [exec_pkg::DATA_W-1:0] quotient,
	input logic [exec_pkg::DATA_W-1:0] remainder,
	input exec_pkg::div_meta_t div_meta,
	input logic issue_is_div,
	output exec_pkg::result_t result,
	output logic lock,
	output logic alu_hold
);

	// Divider wins the port
	always_comb begin
		if (div_valid) begin
			result.valid = 1'b1;
			result.tag = div_meta.tag;
			result.dest = div_meta.dest;
			result.writeback = 1'b1;
			result.data = div_meta.mod_sel ? remainder : quotient;
			result.flags = '0;
			result.flags_wb = 1'b0;
			result.flags_dest = '0;
		end else begin
			result = alu_result;
		end
	end

	// ALU register waits out the divider completion
	assign alu_hold = div_valid;

	// Divide issues still get in, they never touch the ALU register
	assign lock = div_valid && !issue_is_div;

endmodule

`default_nettype wire

// ==== testbench/tb_execute_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_execute_port;
	import exec_pkg::*;

	localparam int DIV_BITS = 4;
	localparam int L = DATA_W / DIV_BITS;
	localparam int ACCEPT_TIMEOUT = 20;
	localparam int DRAIN_TIMEOUT = 4 * L;
	localparam int NUM_RANDOM = 80;

	// One row of the directed table
	typedef struct packed {
		unit_t unit;
		cmd_t cmd;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] exp_data;
		flags_t exp_flags;
	} vec_t;

	logic iCLOCK;
	logic inRESET;
	logic flush;
	issue_t issue;
	result_t result;
	logic lock;

	vec_t vectors[$];
	result_t exp_res [64];
	int acc_cyc [64];
	int div_order[$];
	int alu_order[$];
	logic [TAG_W-1:0] next_tag;
	logic [31:0] lcg_state;
	int cyc = 0;
	int checks = 0;
	int errors = 0;
	int errors_at_start = 0;
	int accepted = 0;
	int completed = 0;
	int lock_cycles = 0;

	execute_port #(
		.DIV_BITS_PER_STAGE(DIV_BITS),
		.FIFO_DEPTH(16),
		.FIFO_DEPTH_W(4)
	) dut0 (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.issue(issue),
		.result(result),
		.lock(lock)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #50 iCLOCK = ~iCLOCK;
	end

	// Cycle count, read only at falling edges
	always @(posedge iCLOCK) begin
		cyc <= cyc + 1;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s expected %h got %h at cycle %0d", name, exp, got, cyc);
		end
	endtask

	task automatic add_vec(
		input unit_t unit,
		input cmd_t cmd,
		input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b,
		input logic [DATA_W-1:0] exp_data,
		input logic [4:0] exp_flags
	);
		vec_t v;
		v.unit = unit;
		v.cmd = cmd;
		v.a = a;
		v.b = b;
		v.exp_data = exp_data;
		v.exp_flags = exp_flags;
		vectors.push_back(v);
	endtask

	// Flags column is {sf, of, cf, pf, zf}
	task automatic load_vectors();
		add_vec(UNIT_LOGIC, CMD_LOGIC_BUF1, 32'h12345678, 32'hdeadbeef, 32'hdeadbeef, 5'b10010);
		add_vec(UNIT_LOGIC, CMD_LOGIC_AND, 32'hf0f0f0f0, 32'h0ff00ff0, 32'h00f000f0, 5'b00000);
		add_vec(UNIT_LOGIC, CMD_LOGIC_OR, 32'h00000001, 32'h80000000, 32'h80000001, 5'b10010);
		add_vec(UNIT_LOGIC, CMD_LOGIC_XOR, 32'haaaaaaaa, 32'haaaaaaaa, 32'h00000000, 5'b00001);
		add_vec(UNIT_LOGIC, CMD_LOGIC_NOT, 32'h00000000, 32'h5555aaaa, 32'hffffffff, 5'b10010);
		add_vec(UNIT_LOGIC, CMD_LOGIC_NAND, 32'hffffffff, 32'hfffffffe, 32'h00000001, 5'b00010);
		add_vec(UNIT_LOGIC, CMD_LOGIC_NOR, 32'h0f0f0000, 32'h00000f0f, 32'hf0f0f0f0, 5'b10000);
		add_vec(UNIT_LOGIC, CMD_LOGIC_XNOR, 32'h12345678, 32'h12345678, 32'hffffffff, 5'b10010);
		add_vec(UNIT_SHIFT, CMD_SHIFT_SLL, 32'h00000001, 32'd31, 32'h80000000, 5'b10000);
		// Only bits 4..0 of the amount count
		add_vec(UNIT_SHIFT, CMD_SHIFT_SRL, 32'h80000000, 32'h00000024, 32'h08000000, 5'b00000);
		add_vec(UNIT_SHIFT, CMD_SHIFT_SRA, 32'h80000000, 32'd4, 32'hf8000000, 5'b10000);
		add_vec(UNIT_SHIFT, CMD_SHIFT_ROL, 32'h80000001, 32'd1, 32'h00000003, 5'b00010);
		add_vec(UNIT_SHIFT, CMD_SHIFT_ROR, 32'h00000001, 32'd1, 32'h80000000, 5'b10000);
		add_vec(UNIT_SHIFT, CMD_SHIFT_ROR, 32'h12345679, 32'd0, 32'h12345679, 5'b00010);
		add_vec(UNIT_ADDER, CMD_ADD, 32'hffffffff, 32'h00000001, 32'h00000000, 5'b00101);
		add_vec(UNIT_ADDER, CMD_ADD, 32'h7fffffff, 32'h00000001, 32'h80000000, 5'b11000);
		add_vec(UNIT_ADDER, CMD_ADD, 32'h80000000, 32'h80000000, 32'h00000000, 5'b01101);
		add_vec(UNIT_ADDER, CMD_SUB, 32'h00000000, 32'h00000001, 32'hffffffff, 5'b10110);
		add_vec(UNIT_ADDER, CMD_SUB, 32'h80000000, 32'h00000001, 32'h7fffffff, 5'b01010);
		add_vec(UNIT_ADDER, CMD_SUB, 32'h00000005, 32'h00000005, 32'h00000000, 5'b00001);
		add_vec(UNIT_MUL, CMD_MUL, 32'h00010000, 32'h00010000, 32'h00000000, 5'b01101);
		add_vec(UNIT_MUL, CMD_MUL, 32'h0000ffff, 32'h0000ffff, 32'hfffe0001, 5'b11010);
		add_vec(UNIT_MUL, CMD_UMULH, 32'hffffffff, 32'hffffffff, 32'hfffffffe, 5'b10000);
		add_vec(UNIT_MUL, CMD_MUL, 32'h00000003, 32'h00000005, 32'h0000000f, 5'b00010);
		add_vec(UNIT_DIV, CMD_UDIV, 32'd100, 32'd7, 32'd14, 5'b00000);
		add_vec(UNIT_DIV, CMD_UMOD, 32'd100, 32'd7, 32'd2, 5'b00000);
		add_vec(UNIT_DIV, CMD_SDIV, 32'hfffffff9, 32'd2, 32'hfffffffd, 5'b00000);
		add_vec(UNIT_DIV, CMD_SMOD, 32'hfffffff9, 32'd2, 32'hffffffff, 5'b00000);
		add_vec(UNIT_DIV, CMD_SDIV, 32'd7, 32'hfffffffe, 32'hfffffffd, 5'b00000);
		add_vec(UNIT_DIV, CMD_SMOD, 32'd7, 32'hfffffffe, 32'h00000001, 5'b00000);
		add_vec(UNIT_DIV, CMD_UDIV, 32'h00001234, 32'd0, 32'hffffffff, 5'b00000);
		add_vec(UNIT_DIV, CMD_UMOD, 32'h00001234, 32'd0, 32'h00001234, 5'b00000);
		add_vec(UNIT_DIV, CMD_SDIV, 32'hfffffffb, 32'd0, 32'hffffffff, 5'b00000);
		add_vec(UNIT_DIV, CMD_SMOD, 32'hfffffffb, 32'd0, 32'hfffffffb, 5'b00000);
		add_vec(UNIT_DIV, CMD_SDIV, 32'h80000000, 32'hffffffff, 32'h80000000, 5'b00000);
		add_vec(UNIT_DIV, CMD_UMOD, 32'hffffffff, 32'h00000010, 32'h0000000f, 5'b00000);
	endtask

	// Expected result straight from the arithmetic rules
	task automatic ref_model(
		input unit_t unit,
		input cmd_t cmd,
		input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b,
		output logic [DATA_W-1:0] data,
		output flags_t flags
	);
		logic [63:0] wide;
		longint sa;
		longint sb;
		longint sr;
		int n;
		logic cf;
		logic of;
		n = b[4:0];
		sa = $signed(a);
		sb = $signed(b);
		data = '0;
		cf = 1'b0;
		of = 1'b0;
		case (unit)
			UNIT_LOGIC: begin
				case (cmd)
					CMD_LOGIC_BUF1: data = b;
					CMD_LOGIC_AND: data = a & b;
					CMD_LOGIC_OR: data = a | b;
					CMD_LOGIC_XOR: data = a ^ b;
					CMD_LOGIC_NOT: data = ~a;
					CMD_LOGIC_NAND: data = ~(a & b);
					CMD_LOGIC_NOR: data = ~(a | b);
					default: data = ~(a ^ b);
				endcase
			end
			UNIT_SHIFT: begin
				case (cmd)
					CMD_SHIFT_SLL: data = a << n;
					CMD_SHIFT_SRL: data = a >> n;
					CMD_SHIFT_SRA: begin
						sr = sa >>> n;
						data = sr[31:0];
					end
					CMD_SHIFT_ROL: data = (n == 0) ? a : ((a << n) | (a >> (32 - n)));
					CMD_SHIFT_ROR: data = (n == 0) ? a : ((a >> n) | (a << (32 - n)));
					default: data = '0;
				endcase
			end
			UNIT_ADDER: begin
				if (cmd == CMD_SUB) begin
					sr = sa - sb;
					data = a - b;
					cf = (a < b);
				end else begin
					sr = sa + sb;
					wide = {32'h0, a} + {32'h0, b};
					data = wide[31:0];
					cf = wide[32];
				end
				// Overflow when the exact signed result leaves 32 bits
				of = (sr[32] != sr[31]);
			end
			UNIT_MUL: begin
				wide = {32'h0, a} * {32'h0, b};
				if (cmd == CMD_UMULH) begin
					data = wide[63:32];
				end else begin
					data = wide[31:0];
					cf = wide[32];
					of = wide[31] ^ wide[32];
				end
			end
			default: begin
				if (b == '0) begin
					data = (cmd == CMD_UMOD || cmd == CMD_SMOD) ? a : '1;
				end else if (cmd == CMD_SDIV) begin
					sr = sa / sb;
					data = sr[31:0];
				end else if (cmd == CMD_SMOD) begin
					sr = sa % sb;
					data = sr[31:0];
				end else if (cmd == CMD_UMOD) begin
					data = a % b;
				end else begin
					data = a / b;
				end
			end
		endcase
		flags = '0;
		if (unit != UNIT_DIV) begin
			flags.sf = data[31];
			flags.of = of;
			flags.cf = cf;
			flags.pf = data[0];
			flags.zf = (data == '0);
		end
	endtask

	task automatic check_result(input int t);
		result_t e;
		e = exp_res[t];
		compare("result.valid", result.valid, 1'b1);
		compare("result.tag", result.tag, e.tag);
		compare("result.dest", result.dest, e.dest);
		compare("result.writeback", result.writeback, e.writeback);
		compare("result.data", result.data, e.data);
		compare("result.flags", result.flags, e.flags);
		compare("result.flags_wb", result.flags_wb, e.flags_wb);
		compare("result.flags_dest", result.flags_dest, e.flags_dest);
		completed++;
	endtask

	// Called once per cycle at the falling edge
	task automatic monitor();
		logic div_due;
		int t;
		div_due = (div_order.size() > 0) && (acc_cyc[div_order[0]] + L == cyc);
		compare("lock", lock, div_due && !(issue.valid && issue.unit == UNIT_DIV));
		if (lock) begin
			lock_cycles++;
		end
		// Divider first, then the oldest ALU operation
		if (div_due) begin
			t = div_order.pop_front();
			check_result(t);
		end else if (alu_order.size() > 0) begin
			t = alu_order.pop_front();
			check_result(t);
		end else begin
			compare("result.valid", result.valid, 1'b0);
		end
	endtask

	task automatic record(
		input issue_t op,
		input logic [DATA_W-1:0] exp_data,
		input flags_t exp_flags
	);
		result_t e;
		e.valid = 1'b1;
		e.tag = op.tag;
		e.dest = op.dest;
		e.data = exp_data;
		if (op.unit == UNIT_DIV) begin
			e.writeback = 1'b1;
			e.flags = '0;
			e.flags_wb = 1'b0;
			e.flags_dest = '0;
			div_order.push_back(op.tag);
		end else begin
			e.writeback = op.writeback;
			e.flags = exp_flags;
			e.flags_wb = op.flags_wb;
			e.flags_dest = op.flags_dest;
			alu_order.push_back(op.tag);
		end
		exp_res[op.tag] = e;
		acc_cyc[op.tag] = cyc;
		accepted++;
	endtask

	function automatic issue_t make_op(
		input unit_t unit,
		input cmd_t cmd,
		input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b
	);
		issue_t op;
		op.valid = 1'b1;
		op.unit = unit;
		op.cmd = cmd;
		op.src0 = a;
		op.src1 = b;
		op.tag = next_tag;
		op.dest = ~next_tag;
		op.writeback = ~next_tag[2];
		op.flags_wb = next_tag[0];
		op.flags_dest = next_tag[4:1];
		next_tag = next_tag + 1'b1;
		return op;
	endfunction

	// Holds the issue until the port takes it
	task automatic present(
		input issue_t op,
		input logic [DATA_W-1:0] exp_data,
		input flags_t exp_flags
	);
		int tries;
		logic taken;
		tries = 0;
		taken = 1'b0;
		issue = op;
		while (!taken && tries < ACCEPT_TIMEOUT) begin
			@(negedge iCLOCK);
			monitor();
			taken = !lock || (op.unit == UNIT_DIV);
			if (taken) begin
				record(op, exp_data, exp_flags);
			end
			@(posedge iCLOCK);
			#5;
			tries++;
		end
		issue.valid = 1'b0;
		if (!taken) begin
			errors++;
			$display("Issue with tag %0d was not accepted within %0d cycles", op.tag, ACCEPT_TIMEOUT);
		end
	endtask

	task automatic apply_vector(input int i);
		vec_t v;
		v = vectors[i];
		present(make_op(v.unit, v.cmd, v.a, v.b), v.exp_data, v.exp_flags);
	endtask

	task automatic idle(input int n);
		issue.valid = 1'b0;
		repeat (n) begin
			@(negedge iCLOCK);
			monitor();
			@(posedge iCLOCK);
			#5;
		end
	endtask

	task automatic drain();
		int tries;
		tries = 0;
		while ((div_order.size() + alu_order.size()) > 0 && tries < DRAIN_TIMEOUT) begin
			idle(1);
			tries++;
		end
		if ((div_order.size() + alu_order.size()) > 0) begin
			errors++;
			$display("%0d expected completions did not arrive within %0d cycles",
				div_order.size() + alu_order.size(), DRAIN_TIMEOUT);
			div_order.delete();
			alu_order.delete();
		end
	endtask

	task automatic random_op(input logic force_div);
		logic [31:0] r;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] data;
		unit_t unit;
		cmd_t cmd;
		flags_t flags;
		r = lcg_next();
		a = lcg_next();
		b = lcg_next();
		case (force_div ? 3'd4 : r[30:28])
			3'd1: begin
				unit = UNIT_SHIFT;
				cmd = cmd_t'(r[27:25] % 5);
			end
			3'd2, 3'd6: begin
				unit = UNIT_ADDER;
				cmd = cmd_t'(r[24]);
			end
			3'd3: begin
				unit = UNIT_MUL;
				cmd = cmd_t'(r[24]);
			end
			3'd4, 3'd5: begin
				unit = UNIT_DIV;
				cmd = cmd_t'(r[25:24]);
				// Smaller divisors, and now and then zero
				b = b >> r[23:19];
				if (r[18:16] == 3'd0) begin
					b = '0;
				end
			end
			default: begin
				unit = UNIT_LOGIC;
				cmd = cmd_t'(r[27:25]);
			end
		endcase
		ref_model(unit, cmd, a, b, data, flags);
		present(make_op(unit, cmd, a, b), data, flags);
	endtask

	task automatic flush_with(input issue_t op);
		issue = op;
		flush = 1'b1;
		@(negedge iCLOCK);
		monitor();
		@(posedge iCLOCK);
		#5;
		flush = 1'b0;
		issue.valid = 1'b0;
		// Nothing in flight survives the flush edge
		div_order.delete();
		alu_order.delete();
	endtask

	task automatic end_test(input string name);
		$display("Test %s finished with %0d failures", name, errors - errors_at_start);
		errors_at_start = errors;
	endtask

	initial begin
		int lock_before;
		int n;
		inRESET = 1'b0;
		flush = 1'b0;
		issue = '0;
		lcg_state = 32'd14;
		next_tag = '0;
		load_vectors();
		repeat (2) @(posedge iCLOCK);
		#5;
		inRESET = 1'b1;

		idle(4);
		end_test("reset");

		foreach (vectors[i]) begin
			if (vectors[i].unit != UNIT_DIV) begin
				apply_vector(i);
			end
		end
		drain();
		end_test("alu_vectors");

		// Back to back, each exactly L cycles later
		foreach (vectors[i]) begin
			if (vectors[i].unit == UNIT_DIV) begin
				apply_vector(i);
			end
		end
		drain();
		end_test("div_vectors");

		for (int i = 0; i < NUM_RANDOM; i++) begin
			random_op(i < 4);
		end
		drain();
		if (completed != accepted) begin
			errors++;
			$display("Accepted %0d operations but saw %0d completions", accepted, completed);
		end
		end_test("random_mix");

		// One divide with a steady ALU stream across its completion
		lock_before = lock_cycles;
		n = 0;
		present(make_op(UNIT_DIV, CMD_UDIV, 32'd1000, 32'd10), 32'd100, '0);
		foreach (vectors[i]) begin
			if (vectors[i].unit != UNIT_DIV && n < L + 2) begin
				apply_vector(i);
				n++;
			end
		end
		drain();
		compare("lock_cycles", lock_cycles - lock_before, 1);
		end_test("lock");

		for (int i = 0; i < 3; i++) begin
			random_op(1'b1);
		end
		apply_vector(0);
		flush_with(make_op(UNIT_ADDER, CMD_ADD, 32'd1, 32'd2));
		idle(L + 2);
		for (int i = 0; i < 4; i++) begin
			apply_vector(i);
		end
		present(make_op(UNIT_DIV, CMD_SDIV, 32'hffffff9c, 32'd7), 32'hfffffff2, '0);
		drain();
		end_test("flush");

		$display("Checks %0d, failures %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire
